/* include/dsp_defs.svh */
`ifndef DSP_DEFS_SVH
`define DSP_DEFS_SVH

// operand widths of the two multipliers
`define DSP_A_W 10
`define DSP_B_W 9

// one packed output lane
`define DSP_LANE_W 19

// holds a product or the sum of two products without overflow
`define DSP_SUM_W 20

// width of the common right shift amount
`define DSP_SHIFT_W 5

// register stages from the input pins to p
`define DSP_LATENCY 5

`endif

/* source/dsp_pkg.sv */
`include "dsp_defs.svh"

package dsp_pkg;

	// selects independent lanes or the multiply-add in lane 0
	typedef enum logic {
		mode_dual = 1'b0,
		mode_sum  = 1'b1
	} dsp_mode_e;

	// internal lane value, wide enough for a1*b1 + a2*b2
	typedef logic signed [`DSP_SUM_W-1:0] dsp_sum_t;

	// one lane as it appears on p
	typedef logic signed [`DSP_LANE_W-1:0] dsp_lane_t;

endpackage

/* source/dsp_lane_if.sv */
`timescale 1ns/1ps
`include "dsp_defs.svh"

// carries one operation per clock from the product stage to the post stage
interface dsp_lane_if;

	// lane values, already combined according to the mode
	dsp_pkg::dsp_sum_t lane0;
	dsp_pkg::dsp_sum_t lane1;

	// controls that travel with the lane values
	logic [`DSP_SHIFT_W-1:0] shift;
	logic round_en;
	logic saturate_en;
	dsp_pkg::dsp_mode_e mode;

	modport producer (
		output lane0, lane1, shift, round_en, saturate_en, mode
	);

	modport consumer (
		input lane0, lane1, shift, round_en, saturate_en, mode
	);

endinterface

/* source/dsp_product_stage.sv */
`timescale 1ns/1ps
`include "dsp_defs.svh"

module dsp_product_stage (
	input logic clk,
	input logic reset,
	input dsp_pkg::dsp_mode_e mode,
	input logic subtract,
	input logic round,
	input logic saturate,
	input logic signed [`DSP_A_W-1:0] a1,
	input logic signed [`DSP_A_W-1:0] a2,
	input logic signed [`DSP_B_W-1:0] b1,
	input logic signed [`DSP_B_W-1:0] b2,
	input logic [`DSP_SHIFT_W-1:0] shift_right,
	dsp_lane_if.producer lanes
);

	logic signed [`DSP_A_W-1:0] a1_q;
	logic signed [`DSP_A_W-1:0] a2_q;
	logic signed [`DSP_B_W-1:0] b1_q;
	logic signed [`DSP_B_W-1:0] b2_q;
	logic [`DSP_SHIFT_W-1:0] shift_q;
	dsp_pkg::dsp_mode_e mode_q;
	logic subtract_q;
	logic round_q;
	logic saturate_q;

	dsp_pkg::dsp_sum_t prod1;
	dsp_pkg::dsp_sum_t prod2;
	dsp_pkg::dsp_sum_t lane0_next;
	dsp_pkg::dsp_sum_t lane1_next;

	// first edge samples operands and controls together
	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			a1_q <= '0;
			a2_q <= '0;
			b1_q <= '0;
			b2_q <= '0;
			shift_q <= '0;
			mode_q <= dsp_pkg::mode_dual;
			subtract_q <= 1'b0;
			round_q <= 1'b0;
			saturate_q <= 1'b0;
		end else begin
			a1_q <= a1;
			a2_q <= a2;
			b1_q <= b1;
			b2_q <= b2;
			shift_q <= shift_right;
			mode_q <= mode;
			subtract_q <= subtract;
			round_q <= round;
			saturate_q <= saturate;
		end
	end

	// operands are sign extended to the full lane width before multiplying
	assign prod1 = a1_q * b1_q;
	assign prod2 = a2_q * b2_q;

	always_comb begin
		if (mode_q == dsp_pkg::mode_sum) begin
			lane0_next = subtract_q ? prod1 - prod2 : prod1 + prod2;
			lane1_next = '0;
		end else begin
			lane0_next = subtract_q ? -prod1 : prod1;
			lane1_next = subtract_q ? -prod2 : prod2;
		end
	end

	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			lanes.lane0 <= '0;
			lanes.lane1 <= '0;
			lanes.shift <= '0;
			lanes.round_en <= 1'b0;
			lanes.saturate_en <= 1'b0;
			lanes.mode <= dsp_pkg::mode_dual;
		end else begin
			lanes.lane0 <= lane0_next;
			lanes.lane1 <= lane1_next;
			lanes.shift <= shift_q;
			lanes.round_en <= round_q;
			lanes.saturate_en <= saturate_q;
			lanes.mode <= mode_q;
		end
	end

endmodule

/* source/dsp_post_stage.sv */
`timescale 1ns/1ps
`include "dsp_defs.svh"

module dsp_post_stage (
	input logic clk,
	input logic reset,
	dsp_lane_if.consumer lanes,
	output logic [2*`DSP_LANE_W-1:0] p
);

	localparam dsp_pkg::dsp_sum_t lane_max =
		dsp_pkg::dsp_sum_t'((2 ** (`DSP_LANE_W - 1)) - 1);
	localparam dsp_pkg::dsp_sum_t lane_min =
		dsp_pkg::dsp_sum_t'(-(2 ** (`DSP_LANE_W - 1)));

	dsp_pkg::dsp_sum_t lane_in [2];
	dsp_pkg::dsp_sum_t shift_next [2];
	dsp_pkg::dsp_sum_t below_point [2];
	logic round_bit_next [2];

	// shift stage
	dsp_pkg::dsp_sum_t shifted [2];
	logic round_bit [2];
	logic round_en_s1;
	logic saturate_en_s1;
	dsp_pkg::dsp_mode_e mode_s1;

	// round stage
	dsp_pkg::dsp_sum_t rounded [2];
	logic saturate_en_s2;
	dsp_pkg::dsp_mode_e mode_s2;

	dsp_pkg::dsp_lane_t lane_out [2];

	// clamps to the signed lane range, or keeps the low bits when wrapping
	function automatic dsp_pkg::dsp_lane_t limit_lane(
		input dsp_pkg::dsp_sum_t value,
		input logic sat_en
	);
		dsp_pkg::dsp_lane_t result;
		result = value[`DSP_LANE_W-1:0];
		if (sat_en && value > lane_max) begin
			result = lane_max[`DSP_LANE_W-1:0];
		end else if (sat_en && value < lane_min) begin
			result = lane_min[`DSP_LANE_W-1:0];
		end
		return result;
	endfunction

	assign lane_in[0] = lanes.lane0;
	assign lane_in[1] = lanes.lane1;

	// the rounding bit is the last bit shifted out
	// an arithmetic shift by shift-1 reads positions past the top as the sign
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			shift_next[i] = lane_in[i] >>> lanes.shift;
			below_point[i] = lane_in[i] >>> (lanes.shift - 1'b1);
			round_bit_next[i] = (lanes.shift != '0) && below_point[i][0];
		end
	end

	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 2; i++) begin
				shifted[i] <= '0;
				round_bit[i] <= 1'b0;
			end
			round_en_s1 <= 1'b0;
			saturate_en_s1 <= 1'b0;
			mode_s1 <= dsp_pkg::mode_dual;
		end else begin
			for (int i = 0; i < 2; i++) begin
				shifted[i] <= shift_next[i];
				round_bit[i] <= round_bit_next[i];
			end
			round_en_s1 <= lanes.round_en;
			saturate_en_s1 <= lanes.saturate_en;
			mode_s1 <= lanes.mode;
		end
	end

	// after a shift of one or more the value is far from the top, so +1 cannot overflow
	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 2; i++) begin
				rounded[i] <= '0;
			end
			saturate_en_s2 <= 1'b0;
			mode_s2 <= dsp_pkg::mode_dual;
		end else begin
			for (int i = 0; i < 2; i++) begin
				rounded[i] <= shifted[i] + dsp_pkg::dsp_sum_t'(round_en_s1 & round_bit[i]);
			end
			saturate_en_s2 <= saturate_en_s1;
			mode_s2 <= mode_s1;
		end
	end

	assign lane_out[0] = limit_lane(rounded[0], saturate_en_s2);
	// lane 1 carries nothing in sum mode
	assign lane_out[1] = (mode_s2 == dsp_pkg::mode_sum) ? '0 :
		limit_lane(rounded[1], saturate_en_s2);

	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			p <= '0;
		end else begin
			p <= {lane_out[1], lane_out[0]};
		end
	end

endmodule

/* source/dsp19x2_mult_add.sv */
`timescale 1ns/1ps
`include "dsp_defs.svh"

// two 19-bit lanes of signed multiply with shift, round and saturate
module dsp19x2_mult_add (
	input logic clk,
	input logic reset,
	input logic mode,
	input logic subtract,
	input logic round,
	input logic saturate,
	input logic signed [`DSP_A_W-1:0] a1,
	input logic signed [`DSP_A_W-1:0] a2,
	input logic signed [`DSP_B_W-1:0] b1,
	input logic signed [`DSP_B_W-1:0] b2,
	input logic [`DSP_SHIFT_W-1:0] shift_right,
	output logic [2*`DSP_LANE_W-1:0] p
);

	dsp_lane_if lanes_if ();

	// mode pin is 0 for dual lanes and 1 for the multiply-add
	dsp_product_stage i_dsp_product_stage (
		.clk(clk),
		.reset(reset),
		.mode(dsp_pkg::dsp_mode_e'(mode)),
		.subtract(subtract),
		.round(round),
		.saturate(saturate),
		.a1(a1),
		.a2(a2),
		.b1(b1),
		.b2(b2),
		.shift_right(shift_right),
		.lanes(lanes_if.producer)
	);

	dsp_post_stage i_dsp_post_stage (
		.clk(clk),
		.reset(reset),
		.lanes(lanes_if.consumer),
		.p(p)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

// free running clock and a reset pulse at the start of the run
module tb_clock_gen (
	output logic clk,
	output logic reset
);

	localparam time half_period = 5ns;
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release lands just after an edge so the first sampled edge is clean
	initial begin
		reset = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b1;
	end

endmodule

/* tb/dsp19x2_tb.sv */
`timescale 1ns/1ps
`include "dsp_defs.svh"

module dsp19x2_tb;

	localparam int wait_limit = 100;

	logic clk;
	logic reset;
	logic mode;
	logic subtract;
	logic round;
	logic saturate;
	logic signed [`DSP_A_W-1:0] a1;
	logic signed [`DSP_A_W-1:0] a2;
	logic signed [`DSP_B_W-1:0] b1;
	logic signed [`DSP_B_W-1:0] b2;
	logic [`DSP_SHIFT_W-1:0] shift_right;
	logic [2*`DSP_LANE_W-1:0] p;

	// expected results travel down a delay line as long as the DUT pipeline
	logic [2*`DSP_LANE_W-1:0] exp_line [`DSP_LATENCY];
	logic [`DSP_LATENCY-1:0] vld_line;
	logic [`DSP_LATENCY-1:0] live_line;
	logic [2*`DSP_LANE_W-1:0] exp_head;
	logic exp_valid;
	logic op_live;

	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	tb_clock_gen i_tb_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	dsp19x2_mult_add i_dsp19x2_mult_add (
		.clk(clk),
		.reset(reset),
		.mode(mode),
		.subtract(subtract),
		.round(round),
		.saturate(saturate),
		.a1(a1),
		.a2(a2),
		.b1(b1),
		.b2(b2),
		.shift_right(shift_right),
		.p(p)
	);

	// shift, round half-up on the last bit shifted out, then clamp or wrap
	function automatic logic [`DSP_LANE_W-1:0] model_lane(
		input longint value,
		input int sh,
		input logic rnd,
		input logic sat
	);
		longint lane_max;
		longint lane_min;
		longint result;
		lane_max = (longint'(1) <<< (`DSP_LANE_W - 1)) - 1;
		lane_min = -(longint'(1) <<< (`DSP_LANE_W - 1));
		result = value >>> sh;
		if (rnd && sh != 0 && value[sh-1]) begin
			result = result + 1;
		end
		if (sat && result > lane_max) begin
			result = lane_max;
		end else if (sat && result < lane_min) begin
			result = lane_min;
		end
		return result[`DSP_LANE_W-1:0];
	endfunction

	function automatic logic [2*`DSP_LANE_W-1:0] expected_p(
		input logic sum_mode,
		input logic sub,
		input logic rnd,
		input logic sat,
		input logic signed [`DSP_A_W-1:0] x1,
		input logic signed [`DSP_A_W-1:0] x2,
		input logic signed [`DSP_B_W-1:0] y1,
		input logic signed [`DSP_B_W-1:0] y2,
		input logic [`DSP_SHIFT_W-1:0] sh
	);
		longint prod1;
		longint prod2;
		logic [`DSP_LANE_W-1:0] out0;
		logic [`DSP_LANE_W-1:0] out1;
		prod1 = longint'(x1) * longint'(y1);
		prod2 = longint'(x2) * longint'(y2);
		if (sum_mode) begin
			out0 = model_lane(sub ? prod1 - prod2 : prod1 + prod2, int'(sh), rnd, sat);
			out1 = '0;
		end else begin
			out0 = model_lane(sub ? -prod1 : prod1, int'(sh), rnd, sat);
			out1 = model_lane(sub ? -prod2 : prod2, int'(sh), rnd, sat);
		end
		return {out1, out0};
	endfunction

	// every edge out of reset is modelled, idle cycles included
	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `DSP_LATENCY; i++) begin
				exp_line[i] <= '0;
			end
			vld_line <= '0;
			live_line <= '0;
		end else begin
			exp_line[0] <= expected_p(mode, subtract, round, saturate,
				a1, a2, b1, b2, shift_right);
			for (int i = 1; i < `DSP_LATENCY; i++) begin
				exp_line[i] <= exp_line[i-1];
			end
			vld_line <= {vld_line[`DSP_LATENCY-2:0], 1'b1};
			live_line <= {live_line[`DSP_LATENCY-2:0], op_live};
		end
	end

	assign exp_head = exp_line[`DSP_LATENCY-1];
	assign exp_valid = vld_line[`DSP_LATENCY-1];

	result_matches: assert property (@(posedge clk) disable iff (!reset)
		exp_valid |-> p == exp_head)
		else begin
			$display("CHECK FAILED p expected %h actual %h", $sampled(exp_head), $sampled(p));
			error_count++;
		end

	zero_in_reset: assert property (@(posedge clk) !reset |-> p == '0)
		else begin
			$display("CHECK FAILED p expected %h actual %h during reset", 38'h0, $sampled(p));
			error_count++;
		end

	// before the first sampled operation arrives the output keeps its reset value
	zero_before_data: assert property (@(posedge clk) disable iff (!reset)
		!exp_valid |-> p == '0)
		else begin
			$display("CHECK FAILED p expected %h actual %h before first result",
				38'h0, $sampled(p));
			error_count++;
		end

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("TESTS FAILED");
		$finish;
	endtask

	function automatic logic random_bit();
		logic [31:0] r;
		r = $urandom;
		return r[0];
	endfunction

	function automatic logic [`DSP_SHIFT_W-1:0] random_shift();
		logic [31:0] r;
		r = $urandom;
		return r[`DSP_SHIFT_W-1:0];
	endfunction

	task automatic apply_op(
		input logic m,
		input logic sub,
		input logic rnd,
		input logic sat,
		input logic [`DSP_A_W-1:0] x1,
		input logic [`DSP_A_W-1:0] x2,
		input logic [`DSP_B_W-1:0] y1,
		input logic [`DSP_B_W-1:0] y2,
		input logic [`DSP_SHIFT_W-1:0] sh
	);
		@(posedge clk);
		#1;
		mode = m;
		subtract = sub;
		round = rnd;
		saturate = sat;
		a1 = x1;
		a2 = x2;
		b1 = y1;
		b2 = y2;
		shift_right = sh;
		op_live = 1'b1;
	endtask

	task automatic apply_random(
		input logic m,
		input logic sub,
		input logic rnd,
		input logic sat,
		input logic [`DSP_SHIFT_W-1:0] sh
	);
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = $urandom;
		r2 = $urandom;
		apply_op(m, sub, rnd, sat, r1[`DSP_A_W-1:0], r1[16+`DSP_A_W-1:16],
			r2[`DSP_B_W-1:0], r2[16+`DSP_B_W-1:16], sh);
	endtask

	task automatic go_idle();
		@(posedge clk);
		#1;
		mode = 1'b0;
		subtract = 1'b0;
		round = 1'b0;
		saturate = 1'b0;
		a1 = '0;
		a2 = '0;
		b1 = '0;
		b2 = '0;
		shift_right = '0;
		op_live = 1'b0;
	endtask

	// reset changes between edges, so it is stable when read at a rising edge
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!reset && cycles < wait_limit);
		if (!reset) begin
			abort_run("reset was not released in time");
		end
	endtask

	// the last live operation leaves the delay line on the edge that checks it
	task automatic drain_pipeline();
		int cycles;
		cycles = 0;
		while (live_line != '0 && cycles < wait_limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (live_line != '0) begin
			abort_run("pipeline did not drain in time");
		end
	endtask

	task automatic close_test(input int num, input string name, input int ops,
		input int errs_before);
		int errs;
		errs = error_count - errs_before;
		if (errs == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %0d %s: %0d operations, %0d errors", num, name, ops, errs);
	endtask

	initial begin
		int errs_before;
		mode = 1'b0;
		subtract = 1'b0;
		round = 1'b0;
		saturate = 1'b0;
		a1 = '0;
		a2 = '0;
		b1 = '0;
		b2 = '0;
		shift_right = '0;
		op_live = 1'b0;
		void'($urandom(32'he63c8738));

		errs_before = error_count;
		wait_reset_release();
		apply_op(1'b0, 1'b0, 1'b0, 1'b0, 10'h003, 10'h3f9, 9'h005, 9'h00b, 5'd0);
		go_idle();
		drain_pipeline();
		close_test(1, "reset and first result", 1, errs_before);

		errs_before = error_count;
		for (int i = 0; i < 200; i++) begin
			apply_random(1'b0, random_bit(), 1'b0, 1'b0, 5'd0);
		end
		go_idle();
		drain_pipeline();
		close_test(2, "dual-mode products", 200, errs_before);

		// large shifts leave only the sign, which is also the rounding bit
		errs_before = error_count;
		for (int i = 0; i < 200; i++) begin
			apply_random(1'b0, random_bit(), random_bit(), 1'b0, random_shift());
		end
		for (int s = 18; s < 32; s++) begin
			apply_op(1'b0, 1'b0, 1'b1, 1'b0, 10'h200, 10'h1ff, 9'h0ff, 9'h0ff, 5'(s));
		end
		go_idle();
		drain_pipeline();
		close_test(3, "shift and rounding", 214, errs_before);

		errs_before = error_count;
		apply_op(1'b1, 1'b0, 1'b0, 1'b1, 10'h200, 10'h200, 9'h100, 9'h100, 5'd0);
		apply_op(1'b1, 1'b0, 1'b0, 1'b0, 10'h200, 10'h200, 9'h100, 9'h100, 5'd0);
		apply_op(1'b1, 1'b1, 1'b0, 1'b1, 10'h200, 10'h1ff, 9'h0ff, 9'h100, 5'd0);
		apply_op(1'b1, 1'b1, 1'b0, 1'b0, 10'h200, 10'h1ff, 9'h0ff, 9'h100, 5'd0);
		apply_op(1'b1, 1'b0, 1'b0, 1'b1, 10'h200, 10'h1ff, 9'h0ff, 9'h100, 5'd0);
		apply_op(1'b1, 1'b1, 1'b0, 1'b0, 10'h1ff, 10'h200, 9'h100, 9'h100, 5'd0);
		apply_op(1'b1, 1'b0, 1'b1, 1'b1, 10'h200, 10'h200, 9'h100, 9'h100, 5'd1);
		for (int i = 0; i < 100; i++) begin
			apply_random(1'b1, random_bit(), random_bit(), random_bit(),
				5'(random_shift() % 4));
		end
		go_idle();
		drain_pipeline();
		close_test(4, "sum mode and saturation", 107, errs_before);

		errs_before = error_count;
		for (int i = 0; i < 400; i++) begin
			apply_random(random_bit(), random_bit(), random_bit(), random_bit(),
				random_shift());
		end
		go_idle();
		drain_pipeline();
		close_test(5, "back-to-back pipeline", 400, errs_before);

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+include
source/dsp_pkg.sv
source/dsp_lane_if.sv
source/dsp_product_stage.sv
source/dsp_post_stage.sv
source/dsp19x2_mult_add.sv
tb/tb_clock_gen.sv
tb/dsp19x2_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the dsp19x2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	--top-module dsp19x2_tb \
	-f list.f \
	-o dsp19x2_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/dsp19x2_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
